//--- common/decoder_pkg.sv
`default_nettype none

package decoder_pkg;

    // lattice size, rows run along X and columns along Z
    localparam int GRID_ROWS = 3;
    localparam int GRID_COLS = 4;
    localparam int UNIT_COUNT = GRID_ROWS * GRID_COLS;
    localparam int ADDR_WIDTH = $clog2(UNIT_COUNT);

    // edge weights per direction
    localparam int WEIGHT_X = 1;
    localparam int WEIGHT_Z = 2;

    // a link is fully grown once both half edges are covered
    localparam int LINK_LENGTH_X = 2 * WEIGHT_X;
    localparam int LINK_LENGTH_Z = 2 * WEIGHT_Z;
    localparam int MAX_LINK_LENGTH =
        (LINK_LENGTH_X > LINK_LENGTH_Z) ? LINK_LENGTH_X : LINK_LENGTH_Z;
    localparam int GROWTH_WIDTH = $clog2(MAX_LINK_LENGTH + 1);

    // link slots of a unit
    localparam int SLOT_UP = 0;
    localparam int SLOT_DOWN = 1;
    localparam int SLOT_LEFT = 2;
    localparam int SLOT_RIGHT = 3;
    localparam int SLOT_COUNT = 4;

    typedef enum logic [1:0] {
        STAGE_IDLE  = 2'd0,
        STAGE_LOAD  = 2'd1,
        STAGE_GROW  = 2'd2,
        STAGE_MERGE = 2'd3
    } stage_t;

    // address is row * GRID_COLS + column
    typedef logic [ADDR_WIDTH-1:0] addr_t;

endpackage

`default_nettype wire

//--- hdl/stage_control.sv
`timescale 1ns/1ps
`default_nettype none

module stage_control (
    input  wire                  clk,
    input  wire                  reset,
    input  wire decoder_pkg::stage_t stage_i,
    input  wire                  root_changed_i,
    output logic                 load_o,
    output logic                 grow_o,
    output logic                 merge_o,
    output logic                 busy_o
);

    decoder_pkg::stage_t stage_q;
    decoder_pkg::stage_t stage_prev_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_q <= decoder_pkg::STAGE_IDLE;
            stage_prev_q <= decoder_pkg::STAGE_IDLE;
            busy_o <= 1'b0;
        end else begin
            stage_q <= stage_i;
            stage_prev_q <= stage_q;
            // any root still moving keeps the grid busy
            busy_o <= root_changed_i;
        end
    end

    assign load_o = (stage_q == decoder_pkg::STAGE_LOAD);
    assign merge_o = (stage_q == decoder_pkg::STAGE_MERGE);

    // one growth step per entry into the grow stage
    assign grow_o = (stage_q == decoder_pkg::STAGE_GROW) &&
                    (stage_prev_q != decoder_pkg::STAGE_GROW);

    grow_single_pulse: assert property (
        @(posedge clk) disable iff (reset)
        grow_o |=> !grow_o
    ) else $error("grow pulse held for more than one cycle");

endmodule

`default_nettype wire

//--- grid/neighbor_link.sv
`timescale 1ns/1ps
`default_nettype none

module neighbor_link #(
    parameter int LINK_LENGTH = decoder_pkg::LINK_LENGTH_X
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     load_i,
    input  wire                     grow_i,
    input  wire                     a_active_i,
    input  wire                     b_active_i,
    input  wire decoder_pkg::addr_t a_root_i,
    input  wire decoder_pkg::addr_t b_root_i,
    output decoder_pkg::addr_t      a_peer_root_o,
    output decoder_pkg::addr_t      b_peer_root_o,
    output logic                    fully_grown_o
);

    logic [decoder_pkg::GROWTH_WIDTH-1:0] count_q;
    logic [decoder_pkg::GROWTH_WIDTH:0]   count_sum;

    // each active end grows the link by one
    assign count_sum = {1'b0, count_q}
                     + (decoder_pkg::GROWTH_WIDTH + 1)'(a_active_i)
                     + (decoder_pkg::GROWTH_WIDTH + 1)'(b_active_i);

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= '0;
        end else if (grow_i) begin
            if (count_sum >= (decoder_pkg::GROWTH_WIDTH + 1)'(LINK_LENGTH)) begin
                count_q <= (decoder_pkg::GROWTH_WIDTH)'(LINK_LENGTH);
            end else begin
                count_q <= count_sum[decoder_pkg::GROWTH_WIDTH-1:0];
            end
        end
    end

    assign fully_grown_o = (count_q == (decoder_pkg::GROWTH_WIDTH)'(LINK_LENGTH));

    // each side sees the root across the link
    assign a_peer_root_o = b_root_i;
    assign b_peer_root_o = a_root_i;

    count_saturates: assert property (
        @(posedge clk) disable iff (reset)
        count_q <= (decoder_pkg::GROWTH_WIDTH)'(LINK_LENGTH)
    ) else $error("link count %0d beyond length %0d", count_q, LINK_LENGTH);

endmodule

`default_nettype wire

//--- grid/processing_unit.sv
`timescale 1ns/1ps
`default_nettype none

module processing_unit #(
    parameter decoder_pkg::addr_t UNIT_ADDR = '0
) (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                load_i,
    input  wire                                merge_i,
    input  wire                                syndrome_i,
    input  wire [decoder_pkg::SLOT_COUNT-1:0]  link_grown_i,
    input  wire decoder_pkg::addr_t            peer_roots_i [decoder_pkg::SLOT_COUNT],
    output decoder_pkg::addr_t                 root_o,
    output logic                               active_o,
    output logic                               root_changed_o
);

    logic               defect_q;
    decoder_pkg::addr_t root_q;
    decoder_pkg::addr_t min_root;

    // smallest root visible over fully grown links
    always_comb begin
        min_root = root_q;
        for (int s = 0; s < decoder_pkg::SLOT_COUNT; s++) begin
            if (link_grown_i[s] && (peer_roots_i[s] < min_root)) begin
                min_root = peer_roots_i[s];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            defect_q <= 1'b0;
            root_q <= UNIT_ADDR;
        end else if (load_i) begin
            defect_q <= syndrome_i;
            root_q <= UNIT_ADDR;
        end else if (merge_i) begin
            root_q <= min_root;
        end
    end

    assign root_o = root_q;

    // a grown link pulls this site into the cluster
    assign active_o = defect_q | (|link_grown_i);

    assign root_changed_o = merge_i && (min_root < root_q);

    // roots only ever come from lower addresses reached through the links
    root_bounded: assert property (
        @(posedge clk) disable iff (reset)
        root_q <= UNIT_ADDR
    ) else $error("unit %0d root %0d above own address", UNIT_ADDR, root_q);

endmodule

`default_nettype wire

//--- grid/unit_grid.sv
`timescale 1ns/1ps
`default_nettype none

module unit_grid (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              load_i,
    input  wire                              grow_i,
    input  wire                              merge_i,
    input  wire [decoder_pkg::UNIT_COUNT-1:0] syndrome_i,
    output wire decoder_pkg::addr_t          roots_o [decoder_pkg::UNIT_COUNT],
    output wire [decoder_pkg::UNIT_COUNT-1:0] active_o,
    output wire                              root_changed_o
);

    wire [decoder_pkg::SLOT_COUNT-1:0] link_grown [decoder_pkg::UNIT_COUNT];
    wire decoder_pkg::addr_t peer_roots [decoder_pkg::UNIT_COUNT][decoder_pkg::SLOT_COUNT];
    wire [decoder_pkg::UNIT_COUNT-1:0] unit_changed;

    // links indexed by their lower address unit
    wire                     x_grown [decoder_pkg::UNIT_COUNT];
    wire decoder_pkg::addr_t x_to_a [decoder_pkg::UNIT_COUNT];
    wire decoder_pkg::addr_t x_to_b [decoder_pkg::UNIT_COUNT];
    wire                     z_grown [decoder_pkg::UNIT_COUNT];
    wire decoder_pkg::addr_t z_to_a [decoder_pkg::UNIT_COUNT];
    wire decoder_pkg::addr_t z_to_b [decoder_pkg::UNIT_COUNT];

    for (genvar a = 0; a < decoder_pkg::UNIT_COUNT; a++) begin : g_site
        processing_unit #(
            .UNIT_ADDR (decoder_pkg::addr_t'(a))
        ) u_unit (
            .clk            (clk),
            .reset          (reset),
            .load_i         (load_i),
            .merge_i        (merge_i),
            .syndrome_i     (syndrome_i[a]),
            .link_grown_i   (link_grown[a]),
            .peer_roots_i   (peer_roots[a]),
            .root_o         (roots_o[a]),
            .active_o       (active_o[a]),
            .root_changed_o (unit_changed[a])
        );

        // X link to the next row
        if (a / decoder_pkg::GRID_COLS < decoder_pkg::GRID_ROWS - 1) begin : g_link_x
            neighbor_link #(
                .LINK_LENGTH (decoder_pkg::LINK_LENGTH_X)
            ) u_link (
                .clk(clk), .reset(reset), .load_i(load_i), .grow_i(grow_i),
                .a_active_i    (active_o[a]),
                .b_active_i    (active_o[a + decoder_pkg::GRID_COLS]),
                .a_root_i      (roots_o[a]),
                .b_root_i      (roots_o[a + decoder_pkg::GRID_COLS]),
                .a_peer_root_o (x_to_a[a]),
                .b_peer_root_o (x_to_b[a]),
                .fully_grown_o (x_grown[a])
            );
        end else begin : g_no_link_x
            assign x_grown[a] = 1'b0;
            assign x_to_a[a] = '1;
            assign x_to_b[a] = '1;
        end

        // Z link to the next column
        if (a % decoder_pkg::GRID_COLS < decoder_pkg::GRID_COLS - 1) begin : g_link_z
            neighbor_link #(
                .LINK_LENGTH (decoder_pkg::LINK_LENGTH_Z)
            ) u_link (
                .clk(clk), .reset(reset), .load_i(load_i), .grow_i(grow_i),
                .a_active_i    (active_o[a]),
                .b_active_i    (active_o[a + 1]),
                .a_root_i      (roots_o[a]),
                .b_root_i      (roots_o[a + 1]),
                .a_peer_root_o (z_to_a[a]),
                .b_peer_root_o (z_to_b[a]),
                .fully_grown_o (z_grown[a])
            );
        end else begin : g_no_link_z
            assign z_grown[a] = 1'b0;
            assign z_to_a[a] = '1;
            assign z_to_b[a] = '1;
        end

        // down and right come from this unit's own links, tied off at the edge
        assign link_grown[a][decoder_pkg::SLOT_DOWN] = x_grown[a];
        assign peer_roots[a][decoder_pkg::SLOT_DOWN] = x_to_a[a];
        assign link_grown[a][decoder_pkg::SLOT_RIGHT] = z_grown[a];
        assign peer_roots[a][decoder_pkg::SLOT_RIGHT] = z_to_a[a];

        if (a / decoder_pkg::GRID_COLS > 0) begin : g_up
            assign link_grown[a][decoder_pkg::SLOT_UP] = x_grown[a - decoder_pkg::GRID_COLS];
            assign peer_roots[a][decoder_pkg::SLOT_UP] = x_to_b[a - decoder_pkg::GRID_COLS];
        end else begin : g_no_up
            assign link_grown[a][decoder_pkg::SLOT_UP] = 1'b0;
            assign peer_roots[a][decoder_pkg::SLOT_UP] = '1;
        end

        if (a % decoder_pkg::GRID_COLS > 0) begin : g_left
            assign link_grown[a][decoder_pkg::SLOT_LEFT] = z_grown[a - 1];
            assign peer_roots[a][decoder_pkg::SLOT_LEFT] = z_to_b[a - 1];
        end else begin : g_no_left
            assign link_grown[a][decoder_pkg::SLOT_LEFT] = 1'b0;
            assign peer_roots[a][decoder_pkg::SLOT_LEFT] = '1;
        end
    end

    assign root_changed_o = |unit_changed;

endmodule

`default_nettype wire

//--- hdl/cluster_decoder_top.sv
`timescale 1ns/1ps
`default_nettype none

module cluster_decoder_top (
    input  wire                              clk,
    input  wire                              reset,
    input  wire decoder_pkg::stage_t         stage_i,
    input  wire [decoder_pkg::UNIT_COUNT-1:0] syndrome_i,
    output wire decoder_pkg::addr_t          roots_o [decoder_pkg::UNIT_COUNT],
    output wire [decoder_pkg::UNIT_COUNT-1:0] active_o,
    output wire                              busy_o
);

    wire load;
    wire grow;
    wire merge;
    wire root_changed;

    // stage sequencing and convergence flag
    stage_control u_stage_control (
        .clk            (clk),
        .reset          (reset),
        .stage_i        (stage_i),
        .root_changed_i (root_changed),
        .load_o         (load),
        .grow_o         (grow),
        .merge_o        (merge),
        .busy_o         (busy_o)
    );

    // lattice of units and links
    unit_grid u_unit_grid (
        .clk            (clk),
        .reset          (reset),
        .load_i         (load),
        .grow_i         (grow),
        .merge_i        (merge),
        .syndrome_i     (syndrome_i),
        .roots_o        (roots_o),
        .active_o       (active_o),
        .root_changed_o (root_changed)
    );

endmodule

`default_nettype wire

//--- verification/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset released just after the last reset edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

`default_nettype wire

//--- verification/tb_cluster_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cluster_decoder;

    localparam int ROWS = decoder_pkg::GRID_ROWS;
    localparam int COLS = decoder_pkg::GRID_COLS;
    localparam int UNITS = decoder_pkg::UNIT_COUNT;

    // cycle budget: idle checks, then each decode run with up to three rounds
    localparam int IDLE_CHECKS = 4;
    localparam int RUN_COUNT = 15;
    localparam int RUN_CYCLES = 2 + 3 * 3 + 1 + 4;
    localparam int CYCLE_LIMIT = 2 + IDLE_CHECKS + 2 + RUN_COUNT * (RUN_CYCLES + UNITS);

    wire clk;
    wire reset;
    decoder_pkg::stage_t stage_i;
    logic [UNITS-1:0] syndrome_i;
    wire decoder_pkg::addr_t roots [UNITS];
    wire [UNITS-1:0] active;
    wire busy;

    string cur_name;
    logic [UNITS-1:0] cur_syndrome;
    int cur_rounds;
    logic busy_seen;
    decoder_pkg::addr_t exp_roots [UNITS];
    logic [UNITS-1:0] exp_active;
    int root_errors = 0;
    int active_errors = 0;
    int busy_errors = 0;
    int cycle_count = 0;
    logic [31:0] rng_state = 32'd86252;
    bit compare_req = 1'b0;

    clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(2)) u_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    cluster_decoder_top uut (
        .clk        (clk),
        .reset      (reset),
        .stage_i    (stage_i),
        .syndrome_i (syndrome_i),
        .roots_o    (roots),
        .active_o   (active),
        .busy_o     (busy)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected outcome of load, grow rounds and a settled merge
    function automatic void reference_decode(input logic [UNITS-1:0] syndrome,
                                             input int rounds);
        int x_count [UNITS];
        int z_count [UNITS];
        logic [UNITS-1:0] act;
        bit changed;
        decoder_pkg::addr_t low;
        for (int u = 0; u < UNITS; u++) begin
            x_count[u] = 0;
            z_count[u] = 0;
            exp_roots[u] = decoder_pkg::addr_t'(u);
        end
        for (int r = 0; r <= rounds; r++) begin
            act = syndrome;
            for (int a = 0; a < UNITS; a++) begin
                if (a / COLS < ROWS - 1 && x_count[a] == decoder_pkg::LINK_LENGTH_X) begin
                    act[a] = 1'b1;
                    act[a + COLS] = 1'b1;
                end
                if (a % COLS < COLS - 1 && z_count[a] == decoder_pkg::LINK_LENGTH_Z) begin
                    act[a] = 1'b1;
                    act[a + 1] = 1'b1;
                end
            end
            if (r < rounds) begin
                for (int a = 0; a < UNITS; a++) begin
                    if (a / COLS < ROWS - 1) begin
                        x_count[a] += int'(act[a]) + int'(act[a + COLS]);
                        if (x_count[a] > decoder_pkg::LINK_LENGTH_X)
                            x_count[a] = decoder_pkg::LINK_LENGTH_X;
                    end
                    if (a % COLS < COLS - 1) begin
                        z_count[a] += int'(act[a]) + int'(act[a + 1]);
                        if (z_count[a] > decoder_pkg::LINK_LENGTH_Z)
                            z_count[a] = decoder_pkg::LINK_LENGTH_Z;
                    end
                end
            end
        end
        exp_active = act;
        // spread the lowest address over every grown link until stable
        do begin
            changed = 1'b0;
            for (int a = 0; a < UNITS; a++) begin
                if (a / COLS < ROWS - 1 && x_count[a] == decoder_pkg::LINK_LENGTH_X &&
                    exp_roots[a] != exp_roots[a + COLS]) begin
                    low = (exp_roots[a] < exp_roots[a + COLS]) ? exp_roots[a] : exp_roots[a + COLS];
                    exp_roots[a] = low;
                    exp_roots[a + COLS] = low;
                    changed = 1'b1;
                end
                if (a % COLS < COLS - 1 && z_count[a] == decoder_pkg::LINK_LENGTH_Z &&
                    exp_roots[a] != exp_roots[a + 1]) begin
                    low = (exp_roots[a] < exp_roots[a + 1]) ? exp_roots[a] : exp_roots[a + 1];
                    exp_roots[a] = low;
                    exp_roots[a + 1] = low;
                    changed = 1'b1;
                end
            end
        end while (changed);
    endfunction

    task automatic check_root(input string name, input int unit,
                              input decoder_pkg::addr_t expected,
                              input decoder_pkg::addr_t actual);
        if (actual !== expected) begin
            root_errors++;
            $display("** Error [%s] unit %0d root: expected %0d, actual %0d",
                     name, unit, expected, actual);
        end
    endtask

    task automatic check_active(input string name, input int unit,
                                input logic expected, input logic actual);
        if (actual !== expected) begin
            active_errors++;
            $display("** Error [%s] unit %0d active: expected %b, actual %b",
                     name, unit, expected, actual);
        end
    endtask

    task automatic check_busy(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            busy_errors++;
            $display("** Error [%s] busy: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // compares the DUT against the reference whenever a checkpoint is raised
    initial begin
        logic exp_busy;
        forever begin
            wait (compare_req);
            reference_decode(cur_syndrome, cur_rounds);
            // busy must rise whenever some root has to move
            exp_busy = 1'b0;
            for (int u = 0; u < UNITS; u++) begin
                check_root(cur_name, u, exp_roots[u], roots[u]);
                check_active(cur_name, u, exp_active[u], active[u]);
                if (exp_roots[u] != decoder_pkg::addr_t'(u))
                    exp_busy = 1'b1;
            end
            check_busy(cur_name, exp_busy, busy_seen);
            compare_req = 1'b0;
        end
    end

    task automatic compare_now();
        compare_req = 1'b1;
        wait (!compare_req);
    endtask

    task automatic drive_stage(input decoder_pkg::stage_t stage, input int cycles);
        stage_i = stage;
        repeat (cycles) @(negedge clk);
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic run_decode(input string name, input logic [UNITS-1:0] syndrome,
                              input int rounds);
        int merge_cycles;
        bit settled;
        cur_name = name;
        cur_syndrome = syndrome;
        cur_rounds = rounds;
        syndrome_i = syndrome;
        drive_stage(decoder_pkg::STAGE_LOAD, 2);
        for (int r = 0; r < rounds; r++) begin
            drive_stage(decoder_pkg::STAGE_GROW, 2);
            drive_stage(decoder_pkg::STAGE_IDLE, 1);
        end
        stage_i = decoder_pkg::STAGE_MERGE;
        merge_cycles = 0;
        settled = 1'b0;
        busy_seen = 1'b0;
        while (!settled) begin
            @(negedge clk);
            merge_cycles++;
            busy_seen = busy_seen | busy;
            if (merge_cycles >= 3 && !busy)
                settled = 1'b1;
        end
        compare_now();
        drive_stage(decoder_pkg::STAGE_IDLE, 1);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        logic [UNITS-1:0] syn;
        int rounds;
        stage_i = decoder_pkg::STAGE_IDLE;
        syndrome_i = '0;
        wait (reset == 1'b0);
        @(negedge clk);

        // idle after reset, nothing loaded yet
        cur_name = "reset_idle";
        cur_syndrome = '0;
        cur_rounds = 0;
        repeat (IDLE_CHECKS) begin
            @(negedge clk);
            busy_seen = busy;
            compare_now();
        end

        run_decode("load_only", 12'h5A3, 0);
        // units 1 and 5 share an X link
        run_decode("x_pair", 12'h022, 1);
        // units 5 and 6 share a Z link of length four
        run_decode("z_pair_one_round", 12'h060, 1);
        run_decode("z_pair_two_rounds", 12'h060, 2);
        run_decode("single_defect", 12'h020, 2);

        for (int t = 0; t < 10; t++) begin
            rng_state = xorshift32(rng_state);
            syn = rng_state[UNITS-1:0];
            rng_state = xorshift32(rng_state);
            rounds = 1 + int'(rng_state % 3);
            run_decode($sformatf("random_%0d", t), syn, rounds);
        end

        $display("root errors %0d, active errors %0d, busy errors %0d",
                 root_errors, active_errors, busy_errors);
        if (root_errors + active_errors + busy_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
common/decoder_pkg.sv
hdl/stage_control.sv
grid/neighbor_link.sv
grid/processing_unit.sv
grid/unit_grid.sv
hdl/cluster_decoder_top.sv
verification/clock_gen.sv
verification/tb_cluster_decoder.sv

//--- Bender.yml
package:
  name: cluster_decoder

sources:
  - common/decoder_pkg.sv
  - hdl/stage_control.sv
  - grid/neighbor_link.sv
  - grid/processing_unit.sv
  - grid/unit_grid.sv
  - hdl/cluster_decoder_top.sv
  - target: test
    files:
      - verification/clock_gen.sv
      - verification/tb_cluster_decoder.sv
